// ==== rover_consts.svh ====
`ifndef ROVER_CONSTS_SVH
`define ROVER_CONSTS_SVH

// NEC timing, one unit is 562.5 us at 50 MHz
`define IR_UNIT_CYCLES       28125
`define IR_LEADER_LOW_UNITS  12    // Minimum leader burst
`define IR_LEADER_HIGH_UNITS 6     // Minimum leader space, rejects repeat codes
`define IR_LEADER_HIGH_MAX   12    // Leader space timeout
`define IR_ONE_UNITS         2     // Space longer than this is a 1
`define IR_ABORT_UNITS       5     // Space longer than this ends the frame
`define IR_SAT_UNITS         16    // Phase counter saturation

// Mode buttons
`define BTN_CAM      8'h0F
`define BTN_IR       8'h13
`define BTN_IDLE     8'h10

// Drive buttons
`define BTN_STOP     8'h0C
`define BTN_LEFT     8'h07
`define BTN_RIGHT    8'h09
`define BTN_FAST     8'h02
`define BTN_MEDIUM   8'h05
`define BTN_SLOW     8'h08
`define BTN_REVERSE  8'h00
`define BTN_LREVERSE 8'h11
`define BTN_RREVERSE 8'h17

`define PWM_BITS     8
`define DUTY_SLOW    64
`define DUTY_MEDIUM  128
`define DUTY_FAST    255
`define DUTY_TURN    128

`endif

// ==== rover_pkg.sv ====
`include "rover_consts.svh"

package rover_pkg;

    typedef logic [7:0] ir_cmd_t;             // Remote button code
    typedef logic [2:0] cam_dir_t;            // 1 left, 2 right, 3 ahead
    typedef logic [1:0] speed_t;              // 3 means too close
    typedef logic [`PWM_BITS-1:0] duty_t;
    typedef logic [6:0] seg7_t;               // Active low, gfedcba

    typedef enum logic [1:0] {
        MODE_IDLE = 2'b00,
        MODE_CAM  = 2'b01,
        MODE_IR   = 2'b10
    } mode_t;

    typedef enum logic [1:0] {
        CAM_SEARCH = 2'b00,
        CAM_FOLLOW = 2'b01,
        CAM_PAUSE  = 2'b11
    } cam_state_t;

    typedef enum logic [3:0] {
        DRV_STOP     = 4'd0,
        DRV_LEFT     = 4'd1,
        DRV_RIGHT    = 4'd2,
        DRV_SLOW     = 4'd3,
        DRV_MEDIUM   = 4'd4,
        DRV_FAST     = 4'd5,
        DRV_REVERSE  = 4'd6,
        DRV_LREVERSE = 4'd7,
        DRV_RREVERSE = 4'd8
    } drive_t;

endpackage

// ==== ir_nec_receiver.sv ====
`timescale 1ns/1ps
`include "rover_consts.svh"

module ir_nec_receiver #(
    parameter int unit_cycles = `IR_UNIT_CYCLES
) (
    input  logic               clk_50,
    input  logic               rst_n,
    input  logic               ir_rx,
    output rover_pkg::ir_cmd_t ir_cmd,
    output logic               ir_cmd_valid
);

    localparam int CNT_W = $clog2(unit_cycles * `IR_SAT_UNITS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(unit_cycles * `IR_SAT_UNITS);
    localparam logic [CNT_W-1:0] LEAD_LOW_MIN = CNT_W'(unit_cycles * `IR_LEADER_LOW_UNITS);
    localparam logic [CNT_W-1:0] LEAD_HIGH_MIN = CNT_W'(unit_cycles * `IR_LEADER_HIGH_UNITS);
    localparam logic [CNT_W-1:0] LEAD_HIGH_MAX = CNT_W'(unit_cycles * `IR_LEADER_HIGH_MAX);
    localparam logic [CNT_W-1:0] ONE_MIN = CNT_W'(unit_cycles * `IR_ONE_UNITS);
    localparam logic [CNT_W-1:0] ABORT_MIN = CNT_W'(unit_cycles * `IR_ABORT_UNITS);

    typedef enum logic [1:0] {
        ST_WAIT_LEADER,
        ST_LEADER_HIGH,
        ST_BITS,
        ST_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_s1;
    logic             rx_s2;
    logic             rx_d;
    logic             rise;
    logic             fall;
    logic             long_high;
    logic             frame_ok;
    logic [CNT_W-1:0] phase_cnt;
    logic [5:0]       bit_cnt;
    logic [31:0]      frame;

    assign rise      = rx_s2 & ~rx_d;            // End of a burst
    assign fall      = ~rx_s2 & rx_d;            // Start of a burst
    assign long_high = rx_s2 && (phase_cnt > ABORT_MIN);
    assign frame_ok  = (frame[7:0] == ~frame[15:8]) && (frame[23:16] == ~frame[31:24]);

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            rx_s1 <= 1'b1;                       // Line idles high
            rx_s2 <= 1'b1;
            rx_d  <= 1'b1;
        end else begin
            rx_s1 <= ir_rx;
            rx_s2 <= rx_s1;
            rx_d  <= rx_s2;
        end
    end

    // Length of the current low or high phase
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            phase_cnt <= '0;
        end else if (rise || fall) begin
            phase_cnt <= '0;
        end else if (phase_cnt != CNT_MAX) begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // Bits shift in LSB first when each space ends
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            frame <= '0;
        end else if (state == ST_BITS && fall) begin
            frame <= {(phase_cnt > ONE_MIN), frame[31:1]};
        end
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            state        <= ST_WAIT_LEADER;
            bit_cnt      <= '0;
            ir_cmd       <= 8'hFF;               // No button
            ir_cmd_valid <= 1'b0;
        end else begin
            ir_cmd_valid <= 1'b0;
            case (state)
                ST_WAIT_LEADER: begin
                    bit_cnt <= '0;
                    if (rise && phase_cnt >= LEAD_LOW_MIN) begin
                        state <= ST_LEADER_HIGH;
                    end
                end
                ST_LEADER_HIGH: begin
                    if (fall) begin
                        state <= (phase_cnt >= LEAD_HIGH_MIN) ? ST_BITS : ST_WAIT_LEADER;
                    end else if (rx_s2 && phase_cnt > LEAD_HIGH_MAX) begin
                        state <= ST_WAIT_LEADER;
                    end
                end
                ST_BITS: begin
                    if (long_high) begin
                        state <= ST_WAIT_LEADER;     // Frame cut off
                    end else if (fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 6'd31) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    if (rise) begin
                        state <= ST_WAIT_LEADER;
                        if (frame_ok) begin
                            ir_cmd       <= frame[23:16];
                            ir_cmd_valid <= 1'b1;
                        end
                    end
                end
                default: state <= ST_WAIT_LEADER;
            endcase
        end
    end

    a_valid_pulse: assert property (@(posedge clk_50) disable iff (!rst_n)
        ir_cmd_valid |=> !ir_cmd_valid);

endmodule

// ==== drive_mode_fsm.sv ====
`timescale 1ns/1ps
`include "rover_consts.svh"

module drive_mode_fsm (
    input  logic                  clk_50,
    input  logic                  rst_n,
    input  rover_pkg::ir_cmd_t    ir_cmd,
    input  logic                  ir_cmd_valid,
    input  rover_pkg::cam_dir_t   cam_direction,
    input  rover_pkg::speed_t     speed,
    input  logic                  orange_detected,
    output rover_pkg::mode_t      mode,
    output rover_pkg::cam_state_t cam_state,
    output rover_pkg::drive_t     drive_state,
    output logic                  mode_change
);
    import rover_pkg::*;

    mode_t      next_mode;
    cam_state_t next_cam;
    drive_t     cam_drive;
    drive_t     ir_drive;
    drive_t     next_drive;

    always_comb begin
        next_mode = mode;
        if (ir_cmd_valid) begin
            case (ir_cmd)
                `BTN_CAM:  next_mode = MODE_CAM;
                `BTN_IR:   next_mode = MODE_IR;
                `BTN_IDLE: next_mode = MODE_IDLE;
                default:   next_mode = mode;     // Drive buttons keep the mode
            endcase
        end
    end

    always_comb begin
        if (next_mode != MODE_CAM) begin
            next_cam = CAM_PAUSE;
        end else begin
            case (cam_state)
                CAM_PAUSE:  next_cam = CAM_SEARCH;
                CAM_SEARCH: next_cam = orange_detected ? CAM_FOLLOW : CAM_SEARCH;
                CAM_FOLLOW: next_cam = orange_detected ? CAM_FOLLOW : CAM_SEARCH;
                default:    next_cam = CAM_PAUSE;
            endcase
        end
    end

    // Camera steering, straight ahead only once the target is locked
    always_comb begin
        cam_drive = DRV_STOP;
        if (next_cam == CAM_SEARCH || next_cam == CAM_FOLLOW) begin
            case (cam_direction)
                3'd1: cam_drive = DRV_LEFT;
                3'd2: cam_drive = DRV_RIGHT;
                3'd3: begin
                    if (next_cam == CAM_FOLLOW) begin
                        case (speed)
                            2'd0:    cam_drive = DRV_SLOW;
                            2'd1:    cam_drive = DRV_MEDIUM;
                            2'd2:    cam_drive = DRV_FAST;
                            default: cam_drive = DRV_STOP;
                        endcase
                    end
                end
                default: cam_drive = DRV_STOP;
            endcase
        end
    end

    // Held code from the receiver
    always_comb begin
        case (ir_cmd)
            `BTN_STOP:     ir_drive = DRV_STOP;
            `BTN_LEFT:     ir_drive = DRV_LEFT;
            `BTN_RIGHT:    ir_drive = DRV_RIGHT;
            `BTN_FAST:     ir_drive = DRV_FAST;
            `BTN_MEDIUM:   ir_drive = DRV_MEDIUM;
            `BTN_SLOW:     ir_drive = DRV_SLOW;
            `BTN_REVERSE:  ir_drive = DRV_REVERSE;
            `BTN_LREVERSE: ir_drive = DRV_LREVERSE;
            `BTN_RREVERSE: ir_drive = DRV_RREVERSE;
            default:       ir_drive = DRV_STOP;
        endcase
    end

    always_comb begin
        case (mode)
            MODE_CAM: next_drive = (speed == 2'd3) ? DRV_STOP : cam_drive;
            MODE_IR:  next_drive = (speed == 2'd3) ? DRV_STOP : ir_drive;
            default:  next_drive = DRV_STOP;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            mode        <= MODE_IDLE;
            cam_state   <= CAM_PAUSE;
            drive_state <= DRV_STOP;
            mode_change <= 1'b0;
        end else begin
            mode        <= next_mode;
            cam_state   <= next_cam;
            drive_state <= next_drive;
            mode_change <= (next_mode != mode) || (next_cam != cam_state);
        end
    end

    a_idle_stop: assert property (@(posedge clk_50) disable iff (!rst_n)
        mode == MODE_IDLE |=> drive_state == DRV_STOP);

endmodule

// ==== motor_pwm.sv ====
`timescale 1ns/1ps
`include "rover_consts.svh"

module motor_pwm (
    input  logic              clk_50,
    input  logic              rst_n,
    input  rover_pkg::drive_t drive_state,
    output logic              motor_l_pwm,
    output logic              motor_r_pwm,
    output logic              motor_l_fwd,
    output logic              motor_r_fwd
);
    import rover_pkg::*;

    localparam duty_t D_OFF    = '0;
    localparam duty_t D_SLOW   = duty_t'(`DUTY_SLOW);
    localparam duty_t D_MEDIUM = duty_t'(`DUTY_MEDIUM);
    localparam duty_t D_FAST   = duty_t'(`DUTY_FAST);
    localparam duty_t D_TURN   = duty_t'(`DUTY_TURN);

    duty_t pwm_cnt;
    duty_t l_nxt;
    duty_t r_nxt;
    duty_t l_cmd;
    duty_t r_cmd;
    duty_t l_duty;
    duty_t r_duty;
    logic  fwd_nxt;

    always_comb begin
        case (drive_state)
            DRV_SLOW:     {l_nxt, r_nxt, fwd_nxt} = {D_SLOW, D_SLOW, 1'b1};
            DRV_MEDIUM:   {l_nxt, r_nxt, fwd_nxt} = {D_MEDIUM, D_MEDIUM, 1'b1};
            DRV_FAST:     {l_nxt, r_nxt, fwd_nxt} = {D_FAST, D_FAST, 1'b1};
            DRV_LEFT:     {l_nxt, r_nxt, fwd_nxt} = {D_OFF, D_TURN, 1'b1};
            DRV_RIGHT:    {l_nxt, r_nxt, fwd_nxt} = {D_TURN, D_OFF, 1'b1};
            DRV_REVERSE:  {l_nxt, r_nxt, fwd_nxt} = {D_TURN, D_TURN, 1'b0};
            DRV_LREVERSE: {l_nxt, r_nxt, fwd_nxt} = {D_OFF, D_TURN, 1'b0};
            DRV_RREVERSE: {l_nxt, r_nxt, fwd_nxt} = {D_TURN, D_OFF, 1'b0};
            default:      {l_nxt, r_nxt, fwd_nxt} = {D_OFF, D_OFF, 1'b1};
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            pwm_cnt     <= '0;
            l_cmd       <= '0;
            r_cmd       <= '0;
            l_duty      <= '0;
            r_duty      <= '0;
            motor_l_fwd <= 1'b1;
            motor_r_fwd <= 1'b1;
        end else begin
            pwm_cnt     <= pwm_cnt + 1'b1;
            l_cmd       <= l_nxt;
            r_cmd       <= r_nxt;
            motor_l_fwd <= fwd_nxt;
            motor_r_fwd <= fwd_nxt;
            if (pwm_cnt == '1) begin             // Load at period boundary
                l_duty <= l_cmd;
                r_duty <= r_cmd;
            end
        end
    end

    assign motor_l_pwm = (pwm_cnt < l_duty);
    assign motor_r_pwm = (pwm_cnt < r_duty);

    a_l_off: assert property (@(posedge clk_50) disable iff (!rst_n)
        (pwm_cnt == '1 && l_cmd == '0) |=> !motor_l_pwm);
    a_r_off: assert property (@(posedge clk_50) disable iff (!rst_n)
        (pwm_cnt == '1 && r_cmd == '0) |=> !motor_r_pwm);

endmodule

// ==== status_display.sv ====
`timescale 1ns/1ps

module status_display (
    input  rover_pkg::mode_t      mode,
    input  rover_pkg::cam_state_t cam_state,
    input  rover_pkg::drive_t     drive_state,
    output rover_pkg::seg7_t      hex0,
    output rover_pkg::seg7_t      hex1,
    output rover_pkg::seg7_t      hex2,
    output rover_pkg::seg7_t      hex3,
    output rover_pkg::seg7_t      hex4,
    output rover_pkg::seg7_t      hex5,
    output rover_pkg::seg7_t      hex6,
    output rover_pkg::seg7_t      hex7
);
    import rover_pkg::*;

    localparam seg7_t SEG_BLANK = 7'b1111111;
    localparam seg7_t SEG_A     = 7'b0001000;
    localparam seg7_t SEG_C     = 7'b1000110;
    localparam seg7_t SEG_D     = 7'b0100001;   // Lower case d
    localparam seg7_t SEG_E     = 7'b0000110;
    localparam seg7_t SEG_F     = 7'b0001110;
    localparam seg7_t SEG_G     = 7'b0000010;
    localparam seg7_t SEG_H     = 7'b0001001;
    localparam seg7_t SEG_I     = 7'b1111001;
    localparam seg7_t SEG_L     = 7'b1000111;
    localparam seg7_t SEG_O     = 7'b1000000;
    localparam seg7_t SEG_P     = 7'b0001100;
    localparam seg7_t SEG_R     = 7'b0101111;   // Lower case r
    localparam seg7_t SEG_S     = 7'b0010010;
    localparam seg7_t SEG_T     = 7'b0000111;   // Lower case t
    localparam seg7_t SEG_1     = 7'b1111001;
    localparam seg7_t SEG_2     = 7'b0100100;
    localparam seg7_t SEG_3     = 7'b0110000;

    assign hex5 = SEG_BLANK;

    always_comb begin
        case (mode)
            MODE_IDLE: {hex7, hex6} = {SEG_I, SEG_D};
            MODE_CAM:  {hex7, hex6} = {SEG_C, SEG_A};
            MODE_IR:   {hex7, hex6} = {SEG_I, SEG_R};
            default:   {hex7, hex6} = {SEG_BLANK, SEG_BLANK};
        endcase

        case (cam_state)
            CAM_SEARCH: hex4 = SEG_S;
            CAM_FOLLOW: hex4 = SEG_F;
            CAM_PAUSE:  hex4 = SEG_P;
            default:    hex4 = SEG_BLANK;
        endcase

        case (drive_state)
            DRV_LEFT:     {hex3, hex2, hex1, hex0} = {SEG_L, SEG_E, SEG_F, SEG_T};
            DRV_RIGHT:    {hex3, hex2, hex1, hex0} = {SEG_R, SEG_G, SEG_H, SEG_T};
            DRV_SLOW:     {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_1};
            DRV_MEDIUM:   {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_2};
            DRV_FAST:     {hex3, hex2, hex1, hex0} = {SEG_S, SEG_P, SEG_BLANK, SEG_3};
            DRV_STOP:     {hex3, hex2, hex1, hex0} = {SEG_S, SEG_T, SEG_O, SEG_P};
            DRV_REVERSE:  {hex3, hex2, hex1, hex0} = {SEG_R, SEG_E, SEG_BLANK, SEG_BLANK};
            DRV_LREVERSE: {hex3, hex2, hex1, hex0} = {SEG_R, SEG_E, SEG_L, SEG_BLANK};
            DRV_RREVERSE: {hex3, hex2, hex1, hex0} = {SEG_R, SEG_E, SEG_R, SEG_BLANK};
            default:      {hex3, hex2, hex1, hex0} = {4{SEG_BLANK}};
        endcase
    end

endmodule

// ==== rover_top.sv ====
`timescale 1ns/1ps
`include "rover_consts.svh"

module rover_top #(
    parameter int unit_cycles = `IR_UNIT_CYCLES
) (
    input  logic                  clk_50,
    input  logic                  rst_n,
    input  logic                  ir_rx,
    input  rover_pkg::cam_dir_t   cam_direction,
    input  rover_pkg::speed_t     speed,
    input  logic                  orange_detected,
    output rover_pkg::mode_t      mode,
    output rover_pkg::cam_state_t cam_state,
    output rover_pkg::drive_t     drive_state,
    output logic                  mode_change,
    output logic                  motor_l_pwm,
    output logic                  motor_r_pwm,
    output logic                  motor_l_fwd,
    output logic                  motor_r_fwd,
    output rover_pkg::seg7_t      hex0,
    output rover_pkg::seg7_t      hex1,
    output rover_pkg::seg7_t      hex2,
    output rover_pkg::seg7_t      hex3,
    output rover_pkg::seg7_t      hex4,
    output rover_pkg::seg7_t      hex5,
    output rover_pkg::seg7_t      hex6,
    output rover_pkg::seg7_t      hex7
);
    import rover_pkg::*;

    ir_cmd_t ir_cmd;
    logic    ir_cmd_valid;

    ir_nec_receiver #(
        .unit_cycles(unit_cycles)
    ) ir_nec_receiver_inst (
        .clk_50       (clk_50),
        .rst_n        (rst_n),
        .ir_rx        (ir_rx),
        .ir_cmd       (ir_cmd),
        .ir_cmd_valid (ir_cmd_valid)
    );

    drive_mode_fsm drive_mode_fsm_inst (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .ir_cmd          (ir_cmd),
        .ir_cmd_valid    (ir_cmd_valid),
        .cam_direction   (cam_direction),
        .speed           (speed),
        .orange_detected (orange_detected),
        .mode            (mode),
        .cam_state       (cam_state),
        .drive_state     (drive_state),
        .mode_change     (mode_change)
    );

    motor_pwm motor_pwm_inst (
        .clk_50      (clk_50),
        .rst_n       (rst_n),
        .drive_state (drive_state),
        .motor_l_pwm (motor_l_pwm),
        .motor_r_pwm (motor_r_pwm),
        .motor_l_fwd (motor_l_fwd),
        .motor_r_fwd (motor_r_fwd)
    );

    status_display status_display_inst (
        .mode        (mode),
        .cam_state   (cam_state),
        .drive_state (drive_state),
        .hex0        (hex0),
        .hex1        (hex1),
        .hex2        (hex2),
        .hex3        (hex3),
        .hex4        (hex4),
        .hex5        (hex5),
        .hex6        (hex6),
        .hex7        (hex7)
    );

endmodule

// ==== tb_rover.sv ====
`timescale 1ns/1ps
`include "rover_consts.svh"

module tb_rover;
    import rover_pkg::*;

    localparam int U = 8;                        // Cycles per NEC unit

    logic       clk_50;
    logic       rst_n;
    logic       ir_rx;
    cam_dir_t   cam_direction;
    speed_t     speed;
    logic       orange_detected;
    mode_t      mode;
    cam_state_t cam_state;
    drive_t     drive_state;
    logic       mode_change;
    logic       motor_l_pwm;
    logic       motor_r_pwm;
    logic       motor_l_fwd;
    logic       motor_r_fwd;
    seg7_t      hex [8];

    logic [31:0] lfsr;
    mode_t       m_mode;
    cam_state_t  m_cam;
    drive_t      m_drive;
    logic        m_change;
    ir_cmd_t     m_cmd;                          // Code held by the receiver
    logic [8:0]  seen;
    int          errors;
    int          test_errs;
    int          tests;
    int          k;

    rover_top #(
        .unit_cycles(U)
    ) rover_top_inst (
        .clk_50          (clk_50),
        .rst_n           (rst_n),
        .ir_rx           (ir_rx),
        .cam_direction   (cam_direction),
        .speed           (speed),
        .orange_detected (orange_detected),
        .mode            (mode),
        .cam_state       (cam_state),
        .drive_state     (drive_state),
        .mode_change     (mode_change),
        .motor_l_pwm     (motor_l_pwm),
        .motor_r_pwm     (motor_r_pwm),
        .motor_l_fwd     (motor_l_fwd),
        .motor_r_fwd     (motor_r_fwd),
        .hex0            (hex[0]),
        .hex1            (hex[1]),
        .hex2            (hex[2]),
        .hex3            (hex[3]),
        .hex4            (hex[4]),
        .hex5            (hex[5]),
        .hex6            (hex[6]),
        .hex7            (hex[7])
    );

    always #2 clk_50 = ~clk_50;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Listed in drive_t order
    function automatic ir_cmd_t drive_btn(input int i);
        case (i)
            0: return `BTN_STOP;
            1: return `BTN_LEFT;
            2: return `BTN_RIGHT;
            3: return `BTN_SLOW;
            4: return `BTN_MEDIUM;
            5: return `BTN_FAST;
            6: return `BTN_REVERSE;
            7: return `BTN_LREVERSE;
            default: return `BTN_RREVERSE;
        endcase
    endfunction

    function automatic drive_t button_drive(input ir_cmd_t cmd);
        for (int i = 0; i < 9; i++) begin
            if (cmd == drive_btn(i)) begin
                return drive_t'(i);
            end
        end
        return DRV_STOP;
    endfunction

    function automatic int duty_of(input drive_t d, input logic right);
        case (d)
            DRV_SLOW:                return `DUTY_SLOW;
            DRV_MEDIUM:              return `DUTY_MEDIUM;
            DRV_FAST:                return `DUTY_FAST;
            DRV_REVERSE:             return `DUTY_TURN;
            DRV_LEFT, DRV_LREVERSE:  return right ? `DUTY_TURN : 0;
            DRV_RIGHT, DRV_RREVERSE: return right ? 0 : `DUTY_TURN;
            default:                 return 0;
        endcase
    endfunction

    function automatic seg7_t seg_of(input logic [7:0] ch);
        case (ch)
            "A":      return 7'b0001000;
            "C":      return 7'b1000110;
            "d":      return 7'b0100001;
            "E":      return 7'b0000110;
            "F":      return 7'b0001110;
            "G":      return 7'b0000010;
            "H":      return 7'b0001001;
            "I", "1": return 7'b1111001;
            "L":      return 7'b1000111;
            "O":      return 7'b1000000;
            "P":      return 7'b0001100;
            "r":      return 7'b0101111;
            "S":      return 7'b0010010;
            "t":      return 7'b0000111;
            "2":      return 7'b0100100;
            "3":      return 7'b0110000;
            default:  return 7'b1111111;
        endcase
    endfunction

    function automatic string drive_text(input drive_t d);
        case (d)
            DRV_LEFT:     return "LEFt";
            DRV_RIGHT:    return "rGHt";
            DRV_SLOW:     return "SP 1";
            DRV_MEDIUM:   return "SP 2";
            DRV_FAST:     return "SP 3";
            DRV_REVERSE:  return "rE  ";
            DRV_LREVERSE: return "rEL ";
            DRV_RREVERSE: return "rEr ";
            default:      return "StOP";
        endcase
    endfunction

    task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("error %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic model_step(input logic valid, input ir_cmd_t cmd);
        mode_t      nm;
        cam_state_t nc;
        drive_t     nd;
        nm = m_mode;
        if (valid) begin
            m_cmd = cmd;
            if (cmd == `BTN_CAM) nm = MODE_CAM;
            else if (cmd == `BTN_IR) nm = MODE_IR;
            else if (cmd == `BTN_IDLE) nm = MODE_IDLE;
        end
        if (nm != MODE_CAM) nc = CAM_PAUSE;
        else if (m_cam == CAM_PAUSE) nc = CAM_SEARCH;
        else nc = orange_detected ? CAM_FOLLOW : CAM_SEARCH;
        nd = DRV_STOP;
        if (speed == 2'd3 || m_mode == MODE_IDLE) nd = DRV_STOP;
        else if (m_mode == MODE_IR) nd = button_drive(m_cmd);
        else if (nc != CAM_PAUSE) begin
            if (cam_direction == 3'd1) nd = DRV_LEFT;
            else if (cam_direction == 3'd2) nd = DRV_RIGHT;
            else if (cam_direction == 3'd3 && nc == CAM_FOLLOW)
                nd = (speed == 2'd0) ? DRV_SLOW : (speed == 2'd1) ? DRV_MEDIUM : DRV_FAST;
        end
        m_change = (nm != m_mode) || (nc != m_cam);
        m_mode = nm;
        m_cam = nc;
        m_drive = nd;
    endtask

    task automatic check_state();
        string      dt;
        string      mt;
        logic [7:0] st;
        dt = drive_text(m_drive);
        mt = (m_mode == MODE_CAM) ? "CA" : (m_mode == MODE_IR) ? "Ir" : "Id";
        st = (m_cam == CAM_SEARCH) ? "S" : (m_cam == CAM_FOLLOW) ? "F" : "P";
        seen[m_drive] = 1'b1;
        expect_val("mode", mode, m_mode);
        expect_val("cam_state", cam_state, m_cam);
        expect_val("drive_state", drive_state, m_drive);
        expect_val("mode_change", mode_change, m_change);
        expect_val("hex7", hex[7], seg_of(mt[0]));
        expect_val("hex6", hex[6], seg_of(mt[1]));
        expect_val("hex5", hex[5], 7'b1111111);
        expect_val("hex4", hex[4], seg_of(st));
        for (int i = 0; i < 4; i++) begin
            expect_val($sformatf("hex%0d", 3 - i), hex[3 - i], seg_of(dt[i]));
        end
    endtask

    // Steps model and DUT by one clock
    task automatic tick(input logic valid, input ir_cmd_t cmd);
        model_step(valid, cmd);
        @(posedge clk_50);
        #1;
        check_state();
    endtask

    task automatic drive_level(input logic level, input int cycles);
        ir_rx = level;
        repeat (cycles) @(posedge clk_50);
        #1;
    endtask

    task automatic send_frame(input ir_cmd_t cmd, input logic corrupt, input int nbits);
        logic [7:0]  addr;
        logic [31:0] word;
        addr = 8'(rand_bits(8));
        word = {~cmd ^ {7'd0, corrupt}, cmd, ~addr, addr};
        drive_level(1'b0, 16 * U);               // Leader burst
        drive_level(1'b1, 8 * U);
        for (int i = 0; i < nbits; i++) begin
            drive_level(1'b0, U);
            drive_level(1'b1, word[i] ? 3 * U : U);
        end
        if (nbits == 32) drive_level(1'b0, U);   // Stop burst
        ir_rx = 1'b1;
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (rover_top_inst.ir_cmd_valid !== 1'b1 && n < 50) begin
            @(posedge clk_50);
            #1;
            n++;
        end
        if (rover_top_inst.ir_cmd_valid !== 1'b1) begin
            abort_run("timeout: the receiver never reported the IR command");
        end
    endtask

    task automatic send_cmd(input ir_cmd_t cmd);
        send_frame(cmd, 1'b0, 32);
        wait_valid();
        tick(1'b1, cmd);
        repeat (3) tick(1'b0, 8'h00);
    endtask

    // Quiet window after a damaged frame
    task automatic expect_no_cmd(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            tick(1'b0, 8'h00);
            if (rover_top_inst.ir_cmd_valid) begin
                errors++;
                test_errs++;
                $display("a damaged frame was decoded as a command at %0t", $time);
            end
        end
    endtask

    task automatic measure_pwm();
        int   lc;
        int   rc;
        logic fwd;
        lc = 0;
        rc = 0;
        repeat (2 * 256) tick(1'b0, 8'h00);     // Let the new duty load
        repeat (256) begin
            tick(1'b0, 8'h00);
            lc += motor_l_pwm;
            rc += motor_r_pwm;
        end
        fwd = !(m_drive inside {DRV_REVERSE, DRV_LREVERSE, DRV_RREVERSE});
        expect_val("left high cycles", lc, duty_of(m_drive, 1'b0));
        expect_val("right high cycles", rc, duty_of(m_drive, 1'b1));
        expect_val("motor_l_fwd", motor_l_fwd, fwd);
        expect_val("motor_r_fwd", motor_r_fwd, fwd);
    endtask

    task automatic finish_test(input string name);
        $display("test %s done with %0d errors", name, test_errs);
        tests++;
        test_errs = 0;
    endtask

    initial begin
        clk_50 = 1'b0;
        rst_n = 1'b0;
        ir_rx = 1'b1;
        cam_direction = '0;
        speed = '0;
        orange_detected = 1'b0;
        lfsr = 32'h3fea_6a42;
        seen = '0;
        errors = 0;
        test_errs = 0;
        tests = 0;
        m_mode = MODE_IDLE;
        m_cam = CAM_PAUSE;
        m_drive = DRV_STOP;
        m_change = 1'b0;
        m_cmd = 8'hFF;
        repeat (8) @(posedge clk_50);
        #1;
        rst_n = 1'b1;
        check_state();
        expect_val("motor_l_pwm", motor_l_pwm, 1'b0);
        expect_val("motor_r_pwm", motor_r_pwm, 1'b0);
        finish_test("reset");

        cam_direction = cam_dir_t'(rand_bits(3));
        speed = speed_t'(rand_bits(2));
        orange_detected = 1'(rand_bits(1));
        for (int i = 0; i < 12; i++) begin
            k = rand_bits(2) % 3;
            send_cmd(k == 0 ? `BTN_CAM : (k == 1 ? `BTN_IR : `BTN_IDLE));
        end
        finish_test("mode buttons");

        send_cmd(`BTN_IDLE);
        send_frame(`BTN_CAM, 1'b1, 32);          // Bad command complement
        expect_no_cmd(20);
        send_frame(`BTN_CAM, 1'b0, 12);          // Frame cut off
        expect_no_cmd(80);
        send_cmd(`BTN_CAM);
        finish_test("damaged frames");

        speed = 2'd0;
        send_cmd(`BTN_IR);
        for (int i = 0; i < 12; i++) begin
            send_cmd(drive_btn(i < 9 ? i : rand_bits(4) % 9));
            measure_pwm();
        end
        finish_test("remote drive");

        send_cmd(`BTN_CAM);
        for (int i = 0; i < 40; i++) begin
            cam_direction = cam_dir_t'(rand_bits(3));
            speed = speed_t'(rand_bits(2));
            orange_detected = 1'(rand_bits(1));
            repeat (4) tick(1'b0, 8'h00);
        end
        finish_test("camera tracking");

        cam_direction = 3'd1;                    // Would steer left below speed 3
        orange_detected = 1'b1;
        speed = 2'd3;
        repeat (4) tick(1'b0, 8'h00);
        expect_val("camera drive at speed 3", drive_state, DRV_STOP);
        send_cmd(`BTN_IR);
        send_cmd(`BTN_FAST);
        expect_val("remote drive at speed 3", drive_state, DRV_STOP);
        speed = 2'd1;
        send_cmd(`BTN_IDLE);
        measure_pwm();
        expect_val("idle drive", drive_state, DRV_STOP);
        finish_test("forced stop");

        if (seen != 9'h1FF) begin
            errors++;
            test_errs++;
            $display("not every drive command was reached, seen mask %0h", seen);
        end
        finish_test("display letters");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
rover_pkg.sv
ir_nec_receiver.sv
drive_mode_fsm.sv
motor_pwm.sv
status_display.sv
rover_top.sv
tb_rover.sv
